//--- bench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
    parameter cpu_types_pkg::addr_t RESET_VECTOR = 16'h0100
) (
    input wire                       clock,
    input wire                       rst_n,
    input wire cpu_types_pkg::addr_t db_address,
    input wire cpu_types_pkg::byte_t db_wdata,
    input wire                       db_nread,
    input wire                       db_nwrite
);
    import cpu_types_pkg::*;

    addr_t exp_addr_q [$];
    byte_t exp_data_q [$];
    int    error_count = 0;
    int    check_count = 0;
    logic  reset_seen = 1'b1;   // DUT has sampled rst_n low
    logic  fetch_seen = 1'b0;

    task automatic expect_write(input addr_t addr, input byte_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    function automatic int pending_writes();
        return exp_addr_q.size();
    endfunction

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout at %0t: %s", $time, what);
        exp_addr_q.delete();   // Drop what is left of this case
        exp_data_q.delete();
    endtask

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("** Error at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    always @(posedge clock)
        reset_seen <= !rst_n;

    // Sampled mid-cycle where outputs have settled
    always @(negedge clock)
    begin
        if (reset_seen)
        begin
            fetch_seen = 1'b0;
            compare("db_nread", 16'd1, {15'd0, db_nread});
            compare("db_nwrite", 16'd1, {15'd0, db_nwrite});
        end
        else
        begin
            if (!fetch_seen && !db_nread)
            begin
                fetch_seen = 1'b1;
                compare("db_address", RESET_VECTOR, db_address);   // First opcode fetch
            end
            if (!db_nwrite)
            begin
                if (exp_addr_q.size() == 0)
                begin
                    error_count++;
                    $display("Unexpected write of %0h to address %0h at %0t",
                             db_wdata, db_address, $time);
                end
                else
                begin
                    compare("db_address", exp_addr_q.pop_front(), db_address);
                    compare("db_wdata", {8'd0, exp_data_q.pop_front()}, {8'd0, db_wdata});
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/cpu_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_sva (
    input wire clock,
    input wire rst_n,
    input wire db_nread,
    input wire db_nwrite,
    input wire execute
);

    // Never a read and a write in the same cycle
    strobes_exclusive: assert property (@(posedge clock) db_nread || db_nwrite)
        else $error("db_nread and db_nwrite both low");

    // Sequencer sees reset one edge later, so check the following cycle
    strobes_idle_in_reset: assert property (@(posedge clock) !rst_n |=> db_nread && db_nwrite)
        else $error("bus strobe active while in reset");

    execute_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) execute |=> !execute
    )
        else $error("execute high for more than one cycle");

endmodule

bind fetch_sequencer cpu_core_sva sva_m (
    .clock    (clock),
    .rst_n    (rst_n),
    .db_nread (db_nread),
    .db_nwrite(db_nwrite),
    .execute  (execute)
);

`default_nettype wire

//--- bench/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    localparam addr_t RESET_VECTOR  = 16'h0100;
    localparam int    FIXED_CASES   = 12;
    localparam int    NUM_CASES     = 20;
    localparam int    WRITE_TIMEOUT = 400;   // Cycles for all four stores
    localparam int    IDLE_CYCLES   = 64;

    logic  clock = 1'b0;
    logic  rst_n;
    byte_t db_rdata;
    addr_t db_address;
    byte_t db_wdata;
    logic  db_nread;
    logic  db_nwrite;

    byte_t mem [65536];
    addr_t build_addr;

    alu_op_t case_op [NUM_CASES];
    byte_t   case_a [NUM_CASES];
    byte_t   case_b [NUM_CASES];
    byte_t   exp_acc [NUM_CASES];
    byte_t   exp_carry [NUM_CASES];
    byte_t   exp_marker [NUM_CASES];

    always #10 clock = ~clock;

    cpu_core #(
        .RESET_VECTOR(RESET_VECTOR)
    ) dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .db_rdata  (db_rdata),
        .db_address(db_address),
        .db_wdata  (db_wdata),
        .db_nread  (db_nread),
        .db_nwrite (db_nwrite)
    );

    cpu_checker #(
        .RESET_VECTOR(RESET_VECTOR)
    ) write_check (
        .clock     (clock),
        .rst_n     (rst_n),
        .db_address(db_address),
        .db_wdata  (db_wdata),
        .db_nread  (db_nread),
        .db_nwrite (db_nwrite)
    );

    // Zero wait state memory
    assign db_rdata = db_nread ? 8'h00 : mem[db_address];

    always @(posedge clock)
    begin
        if (!db_nwrite)
            mem[db_address] <= db_wdata;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [8:0] ref_alu(input alu_op_t op, input byte_t a,
                                           input byte_t b, input logic cin);
        int full;
        full = 0;
        case (op)
            ALU_ADD: full = a + b;
            ALU_ADC: full = a + b + cin;
            ALU_SUB, ALU_CP: full = a - b;
            ALU_SBC: full = a - b - cin;
            ALU_AND: full = a & b;
            ALU_XOR: full = a ^ b;
            default: full = a | b;
        endcase
        // Outside 0..255 means carry out or borrow
        return {(full < 0 || full > 255), full[7:0]};
    endfunction

    task automatic set_row(input int idx, input alu_op_t op, input byte_t a, input byte_t b);
        logic [8:0] first;
        logic [8:0] second;
        logic [8:0] fold;
        logic [8:0] third;
        case_op[idx] = op;
        case_a[idx]  = a;
        case_b[idx]  = b;
        first = ref_alu(op, a, b, 1'b0);   // Flags clear out of reset
        exp_acc[idx] = (op == ALU_CP) ? a : first[7:0];
        second = ref_alu(op, a, b, first[8]);
        fold = ref_alu(ALU_ADC, 8'h00, 8'h00, second[8]);
        exp_carry[idx] = fold[7:0];
        third = ref_alu(op, a, b, fold[8]);
        exp_marker[idx] = (third[7:0] == 8'h00) ? 8'h5A : 8'hA5;
    endtask

    task automatic emit_op(input byte_t opcode);
        mem[build_addr] = opcode;
        build_addr++;
    endtask

    task automatic emit_imm(input byte_t opcode, input byte_t imm);
        emit_op(opcode);
        emit_op(imm);
    endtask

    task automatic emit_jump(input byte_t opcode, input addr_t target);
        emit_op(opcode);
        emit_op(target[7:0]);
        emit_op(target[15:8]);
    endtask

    task automatic load_program(input int idx);
        byte_t alu_r;
        byte_t alu_n;
        alu_r = {2'b10, case_op[idx], 3'b000};   // op with B
        alu_n = {2'b11, case_op[idx], 3'b110};
        build_addr = RESET_VECTOR;
        emit_imm(8'h0E, case_b[idx]);   // ld c, n
        emit_op(8'h41);                 // ld b, c
        emit_imm(8'h3E, case_a[idx]);
        emit_op(alu_r);
        emit_imm(8'h26, 8'h80);
        emit_imm(8'h2E, idx[7:0]);
        emit_op(8'h77);                 // ld (hl), a
        // Immediate form, then carry folded into A by adc
        emit_imm(8'h3E, case_a[idx]);
        emit_imm(alu_n, case_b[idx]);
        emit_imm(8'h3E, 8'h00);
        emit_imm(8'hCE, 8'h00);
        emit_imm(8'h26, 8'h81);
        emit_imm(8'h2E, idx[7:0]);
        emit_op(8'h77);
        emit_imm(8'h3E, case_a[idx]);
        emit_op(alu_r);
        emit_imm(8'h26, 8'h82);
        emit_imm(8'h2E, idx[7:0]);
        emit_imm(8'h3E, 8'h5A);
        emit_jump(8'hCA, build_addr + 16'd5);   // jp z over the A5 load
        emit_imm(8'h3E, 8'hA5);
        emit_op(8'h77);
        emit_imm(8'h26, 8'h90);
        emit_imm(8'h2E, 8'h00);
        emit_op(8'h56);                 // ld d, (hl)
        emit_imm(8'h26, 8'h83);
        emit_imm(8'h2E, idx[7:0]);
        emit_op(8'h72);                 // ld (hl), d
        emit_jump(8'hC3, build_addr);   // Spin in place
    endtask

    task automatic run_case(input int idx);
        int cycles;
        @(posedge clock);
        rst_n <= 1'b0;
        load_program(idx);
        mem[16'h9000] = case_b[idx];
        write_check.expect_write({8'h80, idx[7:0]}, exp_acc[idx]);
        write_check.expect_write({8'h81, idx[7:0]}, exp_carry[idx]);
        write_check.expect_write({8'h82, idx[7:0]}, exp_marker[idx]);
        write_check.expect_write({8'h83, idx[7:0]}, case_b[idx]);
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        cycles = 0;
        while (write_check.pending_writes() != 0 && cycles < WRITE_TIMEOUT)
        begin
            @(posedge clock);
            cycles++;
        end
        if (write_check.pending_writes() != 0)
            write_check.report_timeout($sformatf("case %0d did not finish its stores", idx));
        // Spinning on the jump to self writes nothing
        cycles = 0;
        while (cycles < IDLE_CYCLES)
        begin
            @(posedge clock);
            cycles++;
        end
    endtask

    initial
    begin
        logic [31:0] seed;
        rst_n = 1'b0;
        for (int k = 0; k < 65536; k++)
            mem[k] = k[15:8] ^ k[7:0] ^ 8'h3C;
        set_row(0, ALU_ADD, 8'h12, 8'h34);
        set_row(1, ALU_ADD, 8'hF0, 8'h10);   // Zero with carry
        set_row(2, ALU_ADC, 8'h7F, 8'h01);
        set_row(3, ALU_SUB, 8'h50, 8'h50);
        set_row(4, ALU_SUB, 8'h10, 8'h20);   // Borrow
        set_row(5, ALU_SBC, 8'h00, 8'h01);
        set_row(6, ALU_AND, 8'hF0, 8'h0F);
        set_row(7, ALU_XOR, 8'hAA, 8'h55);
        set_row(8, ALU_XOR, 8'h3C, 8'h3C);
        set_row(9, ALU_OR, 8'h00, 8'h00);
        set_row(10, ALU_CP, 8'h42, 8'h42);
        set_row(11, ALU_CP, 8'h01, 8'h02);
        seed = 32'h13b6c885;
        for (int i = FIXED_CASES; i < NUM_CASES; i++)
        begin
            seed = lcg_next(seed);
            set_row(i, alu_op_t'(seed[26:24]), seed[23:16], seed[15:8]);
        end
        for (int i = 0; i < NUM_CASES; i++)
            run_case(i);
        $display("Checks run: %0d, errors: %0d", write_check.check_count,
                 write_check.error_count);
        if (write_check.error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_isa_pkg::alu_op_t op,
    input  wire cpu_types_pkg::byte_t a,
    input  wire cpu_types_pkg::byte_t b,
    input  wire                       carry_in,
    output cpu_types_pkg::byte_t      result,
    output logic                      carry_out,
    output logic                      zero
);
    import cpu_isa_pkg::*;

    logic [8:0] wide;   // Bit 8 holds carry or borrow

    always_comb
    begin
        wide = '0;
        case (op)
            ALU_ADD:
                wide = {1'b0, a} + {1'b0, b};
            ALU_ADC:
                wide = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
            ALU_SUB, ALU_CP:
                wide = {1'b0, a} - {1'b0, b};   // Wraps to set bit 8 on borrow
            ALU_SBC:
                wide = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
            ALU_AND:
                wide = {1'b0, a & b};
            ALU_XOR:
                wide = {1'b0, a ^ b};
            ALU_OR:
                wide = {1'b0, a | b};
        endcase
    end

    assign result    = wide[7:0];
    assign carry_out = wide[8];
    assign zero      = (wide[7:0] == 8'd0);

endmodule

`default_nettype wire

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter cpu_types_pkg::addr_t RESET_VECTOR = 16'h0100
) (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire cpu_types_pkg::byte_t db_rdata,
    output cpu_types_pkg::addr_t      db_address,
    output cpu_types_pkg::byte_t      db_wdata,
    output logic                      db_nread,
    output logic                      db_nwrite
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    op_class_t op_class;
    reg_idx_t  dst;
    reg_idx_t  src;
    alu_op_t   alu_op;
    cond_t     cond;
    logic      conditional;
    addr_t     operand_word;
    byte_t     mem_byte;
    addr_t     hl;
    logic      jump_taken;
    logic      load_opcode;
    logic      load_lo;
    logic      load_hi;
    logic      load_mem;
    logic      execute;

    fetch_sequencer #(
        .RESET_VECTOR(RESET_VECTOR)
    ) fetch_m (
        .clock       (clock),
        .rst_n       (rst_n),
        .op_class    (op_class),
        .operand_word(operand_word),
        .hl          (hl),
        .jump_taken  (jump_taken),
        .db_address  (db_address),
        .db_nread    (db_nread),
        .db_nwrite   (db_nwrite),
        .load_opcode (load_opcode),
        .load_lo     (load_lo),
        .load_hi     (load_hi),
        .load_mem    (load_mem),
        .execute     (execute)
    );

    decode_latch decode_m (
        .clock       (clock),
        .rst_n       (rst_n),
        .db_rdata    (db_rdata),
        .load_opcode (load_opcode),
        .load_lo     (load_lo),
        .load_hi     (load_hi),
        .load_mem    (load_mem),
        .op_class    (op_class),
        .dst         (dst),
        .src         (src),
        .alu_op      (alu_op),
        .cond        (cond),
        .conditional (conditional),
        .operand_word(operand_word),
        .mem_byte    (mem_byte)
    );

    execute_unit execute_m (
        .clock      (clock),
        .rst_n      (rst_n),
        .execute    (execute),
        .op_class   (op_class),
        .dst        (dst),
        .src        (src),
        .alu_op     (alu_op),
        .cond       (cond),
        .conditional(conditional),
        .imm        (operand_word[7:0]),   // Low operand byte is the immediate
        .mem_byte   (mem_byte),
        .hl         (hl),
        .jump_taken (jump_taken),
        .db_wdata   (db_wdata)
    );

endmodule

`default_nettype wire

//--- hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    // Order matches opcode bits 5 to 3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_LD_RR,
        CLS_LD_RN,
        CLS_LD_R_MEM,
        CLS_ST_MEM_R,
        CLS_ALU_R,
        CLS_ALU_N,
        CLS_JP
    } op_class_t;

    // One state per bus cycle
    typedef enum logic [2:0] {
        SEQ_FETCH,
        SEQ_OPERAND_LO,
        SEQ_OPERAND_HI,
        SEQ_MEM_READ,
        SEQ_MEM_WRITE,
        SEQ_EXECUTE
    } seq_state_t;

    typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_t;   // Opcode bits 4 to 3

    localparam logic [7:0] OPCODE_JP = 8'hC3;   // Unconditional jump

endpackage

`default_nettype wire

//--- hw/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

    // Datapath widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;   // Memory bus address
    typedef logic [2:0]  reg_idx_t;

    // Register numbers as they appear in the opcode ddd and sss fields
    localparam reg_idx_t REG_H   = 3'd4;
    localparam reg_idx_t REG_L   = 3'd5;
    localparam reg_idx_t REG_MEM = 3'd6;   // Memory at H:L, not a register
    localparam reg_idx_t REG_A   = 3'd7;   // Accumulator

endpackage

`default_nettype wire

//--- hw/decode_latch.sv
`timescale 1ns/1ps
`default_nettype none

module decode_latch (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire cpu_types_pkg::byte_t db_rdata,
    input  wire                       load_opcode,
    input  wire                       load_lo,
    input  wire                       load_hi,
    input  wire                       load_mem,
    output cpu_isa_pkg::op_class_t    op_class,
    output cpu_types_pkg::reg_idx_t   dst,
    output cpu_types_pkg::reg_idx_t   src,
    output cpu_isa_pkg::alu_op_t      alu_op,
    output cpu_isa_pkg::cond_t        cond,
    output logic                      conditional,
    output cpu_types_pkg::addr_t      operand_word,
    output cpu_types_pkg::byte_t      mem_byte
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    byte_t opcode;
    byte_t operand_lo;   // Also the immediate byte
    byte_t operand_hi;
    byte_t mem_data;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            opcode <= '0;   // nop
        else if (load_opcode)
            opcode <= db_rdata;
    end

    always_ff @(posedge clock)
    begin
        if (load_lo)
            operand_lo <= db_rdata;
        if (load_hi)
            operand_hi <= db_rdata;
        if (load_mem)
            mem_data <= db_rdata;
    end

    assign dst          = opcode[5:3];
    assign src          = opcode[2:0];
    assign alu_op       = alu_op_t'(opcode[5:3]);
    assign cond         = cond_t'(opcode[4:3]);
    assign conditional  = (opcode != OPCODE_JP);
    assign operand_word = {operand_hi, operand_lo};
    assign mem_byte     = mem_data;

    always_comb
    begin
        op_class = CLS_NOP;
        case (opcode[7:6])
            2'b00:
            begin
                if (src == REG_MEM)
                    op_class = CLS_LD_RN;
            end
            2'b01:
            begin
                if (dst == REG_MEM && src == REG_MEM)
                    op_class = CLS_NOP;   // 0x76
                else if (src == REG_MEM)
                    op_class = CLS_LD_R_MEM;
                else if (dst == REG_MEM)
                    op_class = CLS_ST_MEM_R;
                else
                    op_class = CLS_LD_RR;
            end
            2'b10:
                op_class = CLS_ALU_R;
            default:
            begin
                if (src == REG_MEM)
                    op_class = CLS_ALU_N;
                else if (opcode == OPCODE_JP || (!opcode[5] && src == 3'b010))
                    op_class = CLS_JP;   // C3, C2, CA, D2, DA
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          execute,
    input  wire cpu_isa_pkg::op_class_t  op_class,
    input  wire cpu_types_pkg::reg_idx_t dst,
    input  wire cpu_types_pkg::reg_idx_t src,
    input  wire cpu_isa_pkg::alu_op_t    alu_op,
    input  wire cpu_isa_pkg::cond_t      cond,
    input  wire                          conditional,
    input  wire cpu_types_pkg::byte_t    imm,
    input  wire cpu_types_pkg::byte_t    mem_byte,
    output cpu_types_pkg::addr_t         hl,
    output logic                         jump_taken,
    output cpu_types_pkg::byte_t         db_wdata
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    byte_t    acc;
    byte_t    src_data;
    byte_t    alu_b;
    byte_t    alu_result;
    logic     alu_carry;
    logic     alu_zero;
    logic     is_alu;
    logic     flag_z;
    logic     flag_c;
    logic     cond_met;
    logic     write_enable;
    reg_idx_t write_index;
    byte_t    write_data;

    register_file reg_file_m (
        .clock       (clock),
        .rst_n       (rst_n),
        .write_enable(write_enable),
        .write_index (write_index),
        .read_index_a(REG_A),
        .read_index_b(src),
        .write_data  (write_data),
        .read_data_a (acc),
        .read_data_b (src_data),
        .hl          (hl)
    );

    alu alu_m (
        .op       (alu_op),
        .a        (acc),
        .b        (alu_b),
        .carry_in (flag_c),
        .result   (alu_result),
        .carry_out(alu_carry),
        .zero     (alu_zero)
    );

    assign is_alu   = (op_class == CLS_ALU_R) || (op_class == CLS_ALU_N);
    assign alu_b    = (op_class == CLS_ALU_N) ? imm : src_data;
    assign db_wdata = src_data;   // Store source

    always_comb
    begin
        write_index  = dst;
        write_data   = src_data;
        write_enable = 1'b0;
        case (op_class)
            CLS_LD_RR:
                write_enable = execute;
            CLS_LD_RN:
            begin
                write_data   = imm;
                write_enable = execute;
            end
            CLS_LD_R_MEM:
            begin
                write_data   = mem_byte;
                write_enable = execute;
            end
            CLS_ALU_R, CLS_ALU_N:
            begin
                write_index  = REG_A;
                write_data   = alu_result;
                write_enable = execute && (alu_op != ALU_CP);   // cp keeps A
            end
            default:
                write_enable = 1'b0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (execute && is_alu)
        begin
            flag_z <= alu_zero;
            flag_c <= alu_carry;
        end
    end

    always_comb
    begin
        case (cond)
            COND_NZ: cond_met = !flag_z;
            COND_Z:  cond_met = flag_z;
            COND_NC: cond_met = !flag_c;
            default: cond_met = flag_c;
        endcase
    end

    assign jump_taken = (op_class == CLS_JP) && (!conditional || cond_met);

endmodule

`default_nettype wire

//--- hw/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer #(
    parameter cpu_types_pkg::addr_t RESET_VECTOR = 16'h0000
) (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire cpu_isa_pkg::op_class_t  op_class,
    input  wire cpu_types_pkg::addr_t    operand_word,
    input  wire cpu_types_pkg::addr_t    hl,
    input  wire                          jump_taken,
    output cpu_types_pkg::addr_t         db_address,
    output logic                         db_nread,
    output logic                         db_nwrite,
    output logic                         load_opcode,
    output logic                         load_lo,
    output logic                         load_hi,
    output logic                         load_mem,
    output logic                         execute
);
    import cpu_types_pkg::*;
    import cpu_isa_pkg::*;

    addr_t      pc;
    seq_state_t state_q;
    seq_state_t state;            // Cycle being run now
    seq_state_t state_next;
    logic       running;          // Low through reset and the cycle after it
    logic       decode_pending;   // Set in the cycle right after a fetch

    // Opcode is only latched once fetch ends, so the second cycle is chosen here
    always_comb
    begin
        state = state_q;
        if (decode_pending)
        begin
            case (op_class)
                CLS_LD_RN, CLS_ALU_N, CLS_JP:
                    state = SEQ_OPERAND_LO;
                CLS_LD_R_MEM:
                    state = SEQ_MEM_READ;
                CLS_ST_MEM_R:
                    state = SEQ_MEM_WRITE;
                default:
                    state = SEQ_EXECUTE;
            endcase
        end
    end

    always_comb
    begin
        case (state)
            SEQ_FETCH:
                state_next = SEQ_EXECUTE;   // Replaced by the dispatch above
            SEQ_OPERAND_LO:
                state_next = (op_class == CLS_JP) ? SEQ_OPERAND_HI : SEQ_EXECUTE;
            SEQ_OPERAND_HI, SEQ_MEM_READ:
                state_next = SEQ_EXECUTE;
            default:
                state_next = SEQ_FETCH;
        endcase
    end

    always_comb
    begin
        db_address  = pc;
        db_nread    = 1'b1;
        db_nwrite   = 1'b1;
        load_opcode = 1'b0;
        load_lo     = 1'b0;
        load_hi     = 1'b0;
        load_mem    = 1'b0;
        execute     = 1'b0;
        if (running)
        begin
            case (state)
                SEQ_FETCH:
                begin
                    db_nread    = 1'b0;
                    load_opcode = 1'b1;
                end
                SEQ_OPERAND_LO:
                begin
                    db_nread = 1'b0;
                    load_lo  = 1'b1;
                end
                SEQ_OPERAND_HI:
                begin
                    db_nread = 1'b0;
                    load_hi  = 1'b1;
                end
                SEQ_MEM_READ:
                begin
                    db_address = hl;
                    db_nread   = 1'b0;
                    load_mem   = 1'b1;
                end
                SEQ_MEM_WRITE:
                begin
                    db_address = hl;
                    db_nwrite  = 1'b0;
                end
                default:
                    execute = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pc             <= RESET_VECTOR;
            state_q        <= SEQ_FETCH;
            running        <= 1'b0;
            decode_pending <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (running)
            begin
                state_q        <= state_next;
                decode_pending <= (state == SEQ_FETCH);
                if (load_opcode || load_lo || load_hi)
                    pc <= pc + 16'd1;
                else if (execute && jump_taken)
                    pc <= operand_word;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          write_enable,
    input  wire cpu_types_pkg::reg_idx_t write_index,
    input  wire cpu_types_pkg::reg_idx_t read_index_a,
    input  wire cpu_types_pkg::reg_idx_t read_index_b,
    input  wire cpu_types_pkg::byte_t    write_data,
    output cpu_types_pkg::byte_t         read_data_a,
    output cpu_types_pkg::byte_t         read_data_b,
    output cpu_types_pkg::addr_t         hl
);
    import cpu_types_pkg::*;

    byte_t regs [8];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (write_enable)
        begin
            regs[write_index] <= write_data;
        end
    end

    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];

    // Memory pointer for loads and stores
    assign hl = {regs[REG_H], regs[REG_L]};

endmodule

`default_nettype wire

//--- project.f
hw/cpu_types_pkg.sv
hw/cpu_isa_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/decode_latch.sv
hw/fetch_sequencer.sv
hw/execute_unit.sv
hw/cpu_core.sv
bench/cpu_core_sva.sv
bench/cpu_checker.sv
bench/tb_cpu_core.sv
